// ==== mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

`define BYTE_LEN_IN_BITS    8

// queue geometry
`define ENTRY_WIDTH         64
`define QUEUE_SIZE          16

// scratch memory words
`define MEM_DEPTH           256

// request entry layout, unused bits are zero
`define REQ_DATA_LSB        0
`define REQ_DATA_MSB        31

`define REQ_ADDR_LSB        32
`define REQ_ADDR_MSB        39

`define REQ_MASK_LSB        40
`define REQ_MASK_MSB        43

`define REQ_WRITE_BIT       63  // 1 = write, 0 = read

`endif

// ==== mem_req_pkg.sv ====
`include "mem_defines.svh"

package mem_req_pkg;

    // one queue entry as presented by upstream
    typedef logic [`ENTRY_WIDTH - 1 : 0] req_t;

    // word address into the scratch memory
    typedef logic [`REQ_ADDR_MSB - `REQ_ADDR_LSB : 0] addr_t;

    typedef logic [`REQ_DATA_MSB - `REQ_DATA_LSB : 0] data_t;

    // one bit per data byte
    typedef logic [`REQ_MASK_MSB - `REQ_MASK_LSB : 0] mask_t;

endpackage

// ==== mem_svc_pkg.sv ====
`include "mem_defines.svh"

package mem_svc_pkg;

    typedef enum logic [1 : 0]
    {
        SVC_IDLE,       // waiting for a queued request
        SVC_ACCESS,     // ram read data arrives
        SVC_RESPOND     // response pulse
    } svc_state_e;

    // memory word after the access
    typedef logic [`REQ_DATA_MSB - `REQ_DATA_LSB : 0] resp_t;

endpackage

// ==== dual_port_blockram.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module dual_port_blockram
#(
    parameter  int ENTRY_BITS = 32,
    parameter  int NUM_SET    = 256,
    localparam int ADDR_BITS  = $clog2(NUM_SET),
    localparam int MASK_BITS  = ENTRY_BITS / `BYTE_LEN_IN_BITS
)
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  logic [ADDR_BITS - 1 : 0]    a_addr,
    input  logic [MASK_BITS - 1 : 0]    a_we,
    input  logic [ENTRY_BITS - 1 : 0]   a_wdata,
    output logic [ENTRY_BITS - 1 : 0]   a_rdata,

    input  logic [ADDR_BITS - 1 : 0]    b_addr,
    input  logic [MASK_BITS - 1 : 0]    b_we,
    input  logic [ENTRY_BITS - 1 : 0]   b_wdata,
    output logic [ENTRY_BITS - 1 : 0]   b_rdata
);

logic [ENTRY_BITS - 1 : 0] mem [NUM_SET];

logic [ENTRY_BITS - 1 : 0] a_next;
logic [ENTRY_BITS - 1 : 0] b_next;

// word as it stands after the enabled bytes are replaced
function automatic logic [ENTRY_BITS - 1 : 0] merge_bytes
(
    input logic [ENTRY_BITS - 1 : 0] old_word,
    input logic [MASK_BITS - 1 : 0]  we,
    input logic [ENTRY_BITS - 1 : 0] wdata
);
    logic [ENTRY_BITS - 1 : 0] word;
    word = old_word;
    for (int i = 0; i < MASK_BITS; i++)
    begin
        if (we[i])
        begin
            word[i * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] =
                wdata[i * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
        end
    end
    return word;
endfunction

assign a_next = merge_bytes(mem[a_addr], a_we, a_wdata);
assign b_next = merge_bytes(mem[b_addr], b_we, b_wdata);

always_ff @(posedge clk_in)
begin
    if (|a_we)
    begin
        mem[a_addr] <= a_next;
    end
    if (|b_we)
    begin
        mem[b_addr] <= b_next;  // port b wins a same-address collision
    end
end

// write-first on each port
always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        a_rdata <= '0;
        b_rdata <= '0;
    end
    else
    begin
        a_rdata <= a_next;
        b_rdata <= b_next;
    end
end

endmodule

// ==== fifo_queue.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module fifo_queue
#(
    parameter string STORAGE_TYPE = "BlockRAM"    // FlipFlop or BlockRAM
)
(
    input  logic                clk_in,
    input  logic                reset_in,

    output logic                is_empty_out,
    output logic                is_full_out,

    input  mem_req_pkg::req_t   request_in,
    input  logic                request_valid_in,
    output logic                issue_ack_out,

    output mem_req_pkg::req_t   request_out,
    output logic                request_valid_out,
    input  logic                issue_ack_in
);

localparam int PTR_BITS  = $clog2(`QUEUE_SIZE);
localparam int MASK_BITS = `ENTRY_WIDTH / `BYTE_LEN_IN_BITS;

logic [`QUEUE_SIZE - 1 : 0] entry_valid;

logic [PTR_BITS - 1 : 0]    write_ptr;
logic [PTR_BITS - 1 : 0]    read_ptr;
logic [PTR_BITS - 1 : 0]    next_write_ptr;
logic [PTR_BITS - 1 : 0]    next_read_ptr;

logic                       write_en;
logic                       pop;
logic                       bypass;

mem_req_pkg::req_t          head_entry;
logic                       head_ready;     // head_entry matches the stored head

assign next_write_ptr = (write_ptr == PTR_BITS'(`QUEUE_SIZE - 1)) ? '0 : write_ptr + 1'b1;
assign next_read_ptr  = (read_ptr == PTR_BITS'(`QUEUE_SIZE - 1)) ? '0 : read_ptr + 1'b1;

assign is_full_out  = &entry_valid;
assign is_empty_out = ~|entry_valid;

assign pop      = issue_ack_in & request_valid_out;
// when full, only the slot freed by a same-cycle pop takes the write
assign write_en = request_valid_in & ~issue_ack_out & (~is_full_out | pop);
assign bypass   = write_en & ~entry_valid[read_ptr] & (write_ptr == read_ptr);

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        write_ptr         <= '0;
        read_ptr          <= '0;
        entry_valid       <= '0;
        issue_ack_out     <= 1'b0;
        request_valid_out <= 1'b0;
    end
    else
    begin
        issue_ack_out <= write_en;

        if (pop)
        begin
            entry_valid[read_ptr] <= 1'b0;
            read_ptr              <= next_read_ptr;
        end
        if (write_en)
        begin
            entry_valid[write_ptr] <= 1'b1;    // overrides the pop on a full queue
            write_ptr              <= next_write_ptr;
        end

        if (pop)
        begin
            request_valid_out <= 1'b0;
        end
        else if (~request_valid_out & ((entry_valid[read_ptr] & head_ready) | bypass))
        begin
            request_valid_out <= 1'b1;
        end
    end
end

// output word reloads until it is marked valid
always_ff @(posedge clk_in)
begin
    if (~request_valid_out)
    begin
        if (entry_valid[read_ptr])
        begin
            request_out <= head_entry;
        end
        else
        begin
            request_out <= request_in;  // fast path into an empty head
        end
    end
end

if (STORAGE_TYPE == "FlipFlop")
begin : g_flops
    mem_req_pkg::req_t entries [`QUEUE_SIZE];

    always_ff @(posedge clk_in)
    begin
        if (write_en)
        begin
            entries[write_ptr] <= request_in;
        end
    end

    assign head_entry = entries[read_ptr];
    assign head_ready = 1'b1;
end
else
begin : g_bram
    logic [PTR_BITS - 1 : 0] rd_addr;
    logic                    rd_stale;
    mem_req_pkg::req_t       rd_data;

    // read one ahead on a pop so the next head is ready a cycle later
    assign rd_addr = pop ? next_read_ptr : read_ptr;

    dual_port_blockram
    #(
        .ENTRY_BITS (`ENTRY_WIDTH),
        .NUM_SET    (`QUEUE_SIZE)
    )
    i_storage
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .a_addr     (write_ptr),
        .a_we       ({MASK_BITS{write_en}}),
        .a_wdata    (request_in),
        .a_rdata    (),
        .b_addr     (rd_addr),
        .b_we       ('0),
        .b_wdata    ('0),
        .b_rdata    (rd_data)
    );

    // port b missed a port a write to the same slot, so read it again
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            rd_stale <= 1'b0;
        end
        else
        begin
            rd_stale <= write_en & (write_ptr == rd_addr);
        end
    end

    assign head_entry = rd_data;
    assign head_ready = ~rd_stale;
end

endmodule

// ==== request_servicer.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module request_servicer
(
    input  logic                clk_in,
    input  logic                reset_in,

    input  mem_req_pkg::req_t   request_in,
    input  logic                request_valid_in,
    output logic                issue_ack_out,

    output mem_req_pkg::addr_t  mem_addr_out,
    output mem_req_pkg::mask_t  mem_we_out,
    output mem_req_pkg::data_t  mem_wdata_out,
    input  mem_req_pkg::data_t  mem_rdata_in,

    output logic                resp_valid_out,
    output mem_svc_pkg::resp_t  resp_data_out,
    output mem_req_pkg::addr_t  resp_addr_out
);

mem_svc_pkg::svc_state_e state;

logic               is_write;
mem_req_pkg::mask_t byte_mask;

assign is_write  = request_in[`REQ_WRITE_BIT];
assign byte_mask = request_in[`REQ_MASK_MSB : `REQ_MASK_LSB];

// accept in the first idle cycle the head is valid
assign issue_ack_out = (state == mem_svc_pkg::SVC_IDLE) & request_valid_in;

// port a sees the request during the acknowledge cycle
assign mem_addr_out  = request_in[`REQ_ADDR_MSB : `REQ_ADDR_LSB];
assign mem_wdata_out = request_in[`REQ_DATA_MSB : `REQ_DATA_LSB];
assign mem_we_out    = (issue_ack_out & is_write) ? byte_mask : '0;    // reads write nothing

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        state          <= mem_svc_pkg::SVC_IDLE;
        resp_valid_out <= 1'b0;
    end
    else
    begin
        case (state)
            mem_svc_pkg::SVC_IDLE:
            begin
                if (issue_ack_out)
                begin
                    state <= mem_svc_pkg::SVC_ACCESS;
                end
            end
            mem_svc_pkg::SVC_ACCESS:
            begin
                state          <= mem_svc_pkg::SVC_RESPOND;
                resp_valid_out <= 1'b1;
            end
            mem_svc_pkg::SVC_RESPOND:
            begin
                state          <= mem_svc_pkg::SVC_IDLE;
                resp_valid_out <= 1'b0;
            end
            default:
            begin
                state          <= mem_svc_pkg::SVC_IDLE;
                resp_valid_out <= 1'b0;
            end
        endcase
    end
end

always_ff @(posedge clk_in)
begin
    if (issue_ack_out)
    begin
        resp_addr_out <= mem_addr_out;  // request leaves the queue after this cycle
    end
    if (state == mem_svc_pkg::SVC_ACCESS)
    begin
        resp_data_out <= mem_rdata_in;  // write-first word, new data on a write
    end
end

endmodule

// ==== mem_request_unit.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_request_unit
#(
    parameter string STORAGE_TYPE = "BlockRAM"
)
(
    input  logic                clk_in,
    input  logic                reset_in,

    input  mem_req_pkg::req_t   request_in,
    input  logic                request_valid_in,
    output logic                issue_ack_out,
    output logic                is_full_out,
    output logic                is_empty_out,

    output logic                resp_valid_out,
    output mem_svc_pkg::resp_t  resp_data_out,
    output mem_req_pkg::addr_t  resp_addr_out
);

mem_req_pkg::req_t  head_request;
logic               head_valid;
logic               head_ack;

mem_req_pkg::addr_t ram_addr;
mem_req_pkg::mask_t ram_we;
mem_req_pkg::data_t ram_wdata;
mem_req_pkg::data_t ram_rdata;

fifo_queue
#(
    .STORAGE_TYPE       (STORAGE_TYPE)
)
i_queue
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .is_empty_out       (is_empty_out),
    .is_full_out        (is_full_out),
    .request_in         (request_in),
    .request_valid_in   (request_valid_in),
    .issue_ack_out      (issue_ack_out),
    .request_out        (head_request),
    .request_valid_out  (head_valid),
    .issue_ack_in       (head_ack)
);

request_servicer i_servicer
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .request_in         (head_request),
    .request_valid_in   (head_valid),
    .issue_ack_out      (head_ack),
    .mem_addr_out       (ram_addr),
    .mem_we_out         (ram_we),
    .mem_wdata_out      (ram_wdata),
    .mem_rdata_in       (ram_rdata),
    .resp_valid_out     (resp_valid_out),
    .resp_data_out      (resp_data_out),
    .resp_addr_out      (resp_addr_out)
);

// scratch memory, port b unused
dual_port_blockram
#(
    .ENTRY_BITS         ($bits(mem_req_pkg::data_t)),
    .NUM_SET            (`MEM_DEPTH)
)
i_scratch_ram
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .a_addr             (ram_addr),
    .a_we               (ram_we),
    .a_wdata            (ram_wdata),
    .a_rdata            (ram_rdata),
    .b_addr             ('0),
    .b_we               ('0),
    .b_wdata            ('0),
    .b_rdata            ()
);

endmodule

// ==== tb_mem_request_unit.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_request_unit;

localparam int CLK_PERIOD     = 100;
localparam int FILL_LEN       = 16;
localparam int BURST_LEN      = 200;
localparam int NUM_REQUESTS   = FILL_LEN + 2 + 8 + BURST_LEN;
localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 8 + 200;

logic               clk_in;
logic               reset_in;
mem_req_pkg::req_t  request_in;
logic               request_valid_in;
logic               issue_ack_out;
logic               is_full_out;
logic               is_empty_out;
logic               resp_valid_out;
mem_svc_pkg::resp_t resp_data_out;
mem_req_pkg::addr_t resp_addr_out;

mem_req_pkg::data_t model_mem [`MEM_DEPTH];    // reference copy of the scratch memory
mem_req_pkg::req_t  exp_req_q [$];             // accepted requests in acceptance order
string              exp_name_q [$];
int                 resp_count  = 0;
logic               seen_full   = 1'b0;
logic               full_no_pop = 1'b0;

mem_request_unit i_mem_request_unit
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .request_in         (request_in),
    .request_valid_in   (request_valid_in),
    .issue_ack_out      (issue_ack_out),
    .is_full_out        (is_full_out),
    .is_empty_out       (is_empty_out),
    .resp_valid_out     (resp_valid_out),
    .resp_data_out      (resp_data_out),
    .resp_addr_out      (resp_addr_out)
);

initial
begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
end

function automatic mem_req_pkg::req_t make_request
(
    input logic               is_write,
    input mem_req_pkg::addr_t addr,
    input mem_req_pkg::mask_t mask,
    input mem_req_pkg::data_t data
);
    mem_req_pkg::req_t req;
    req                                   = '0;
    req[`REQ_WRITE_BIT]                   = is_write;
    req[`REQ_MASK_MSB : `REQ_MASK_LSB]    = mask;
    req[`REQ_ADDR_MSB : `REQ_ADDR_LSB]    = addr;
    req[`REQ_DATA_MSB : `REQ_DATA_LSB]    = data;
    return req;
endfunction

// memory word after the request with its masked bytes taken from the request
function automatic mem_req_pkg::data_t apply_request
(
    input mem_req_pkg::req_t  req,
    input mem_req_pkg::data_t old_word
);
    mem_req_pkg::data_t word;
    word = old_word;
    if (req[`REQ_WRITE_BIT])
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (req[`REQ_MASK_LSB + i])
            begin
                word[i * 8 +: 8] = req[`REQ_DATA_LSB + i * 8 +: 8];
            end
        end
    end
    return word;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected)
    begin
        $display("Error: %s expected %h actual %h", name, expected, actual);
        $display("Verification failed");
        $fatal(1);
    end
endtask

// hold the request until the queue acknowledges it
task automatic send_request(input string name, input mem_req_pkg::req_t req);
    request_in       <= req;
    request_valid_in <= 1'b1;
    @(posedge clk_in);
    while (issue_ack_out !== 1'b1)
    begin
        @(posedge clk_in);
    end
    exp_req_q.push_back(req);
    exp_name_q.push_back(name);
endtask

initial
begin : stimulus
    mem_req_pkg::addr_t addr;
    mem_req_pkg::mask_t mask;
    mem_req_pkg::data_t data;
    logic               is_write;
    mem_req_pkg::mask_t partial_masks [4];
    partial_masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    void'($urandom(71528));
    reset_in         = 1'b1;
    request_in       = '0;
    request_valid_in = 1'b0;
    for (int i = 0; i < `MEM_DEPTH; i++)
    begin
        model_mem[i] = '0;
    end
    repeat (3) @(posedge clk_in);
    reset_in <= 1'b0;
    @(posedge clk_in);
    check_value("reset_empty", 32'd1, 32'(is_empty_out));
    check_value("reset_ack", 32'd0, 32'(issue_ack_out));
    check_value("reset_resp", 32'd0, 32'(resp_valid_out));

    for (int i = 0; i < FILL_LEN; i++)    // every burst address gets a known word first
    begin
        addr = mem_req_pkg::addr_t'(i);
        data = {addr, ~addr, addr ^ 8'h5a, addr + 8'h11};
        send_request("fill", make_request(1'b1, addr, 4'hf, data));
    end
    send_request("write_read", make_request(1'b1, 8'd3, 4'hf, 32'h1234_5678));
    send_request("write_read", make_request(1'b0, 8'd3, 4'h0, 32'h0));
    for (int i = 0; i < 4; i++)
    begin
        data = $urandom;
        send_request("partial_mask", make_request(1'b1, 8'd5, partial_masks[i], data));
        send_request("partial_mask", make_request(1'b0, 8'd5, 4'h0, 32'h0));
    end
    for (int i = 0; i < BURST_LEN; i++)
    begin
        addr     = mem_req_pkg::addr_t'($urandom_range(15, 0));
        is_write = 1'($urandom_range(1, 0));
        mask     = is_write ? mem_req_pkg::mask_t'($urandom_range(15, 0)) : 4'h0;
        data     = $urandom;
        send_request("burst", make_request(is_write, addr, mask, data));
    end
    request_valid_in <= 1'b0;

    while (is_empty_out !== 1'b1)
    begin
        @(posedge clk_in);
    end
    repeat (10) @(posedge clk_in);    // last pop is answered two cycles later
    check_value("response_count", NUM_REQUESTS, resp_count);
    if (!seen_full)
    begin
        $display("Error: the queue never reported full during the burst");
        $display("Verification failed");
        $fatal(1);
    end
    else
    begin
        $display("Verification passed");
        $finish;
    end
end

initial
begin : compare_responses
    mem_req_pkg::req_t  req;
    mem_req_pkg::addr_t addr;
    mem_req_pkg::data_t expected;
    string              name;
    forever
    begin
        @(posedge clk_in);
        if (!reset_in && resp_valid_out === 1'b1)
        begin
            if (exp_req_q.size() == 0)
            begin
                $display("Error: a response arrived with no request outstanding");
                $display("Verification failed");
                $fatal(1);
            end
            else
            begin
                req            = exp_req_q.pop_front();
                name           = exp_name_q.pop_front();
                addr           = req[`REQ_ADDR_MSB : `REQ_ADDR_LSB];
                expected       = apply_request(req, model_mem[addr]);
                model_mem[addr] = expected;
                check_value({name, "_data"}, expected, resp_data_out);
                check_value({name, "_addr"}, 32'(addr), 32'(resp_addr_out));
                resp_count++;
            end
        end
    end
end

// a full queue with no pop must not acknowledge in the next cycle
initial
begin : watch_full
    forever
    begin
        @(posedge clk_in);
        if (!reset_in)
        begin
            if (full_no_pop)
            begin
                check_value("full_holds_ack", 32'd0, 32'(issue_ack_out));
            end
            if (is_full_out)
            begin
                seen_full = 1'b1;
            end
            full_no_pop = is_full_out
                & ~(i_mem_request_unit.head_valid & i_mem_request_unit.head_ack);
        end
    end
end

initial
begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_in);
    $display("Error: the run timed out before all responses arrived");
    $display("Verification failed");
    $fatal(1);
end

endmodule

// ==== vlog.f ====
+incdir+.
mem_req_pkg.sv
mem_svc_pkg.sv
dual_port_blockram.sv
fifo_queue.sv
request_servicer.sv
mem_request_unit.sv
tb_mem_request_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal \
    --top-module tb_mem_request_unit \
    -f vlog.f --Mdir obj_dir -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ;
cat sim.log &&
test -s sim.log &&
! grep -q "Verification failed" sim.log &&
echo "simulation run ok" ||
{ echo "simulation run failed, see build.log and sim.log"; exit 1; }
